// File: logic/adam_ctrl_pkg.sv
/* Shared types and constants of the controller input path.
   Active-low port lines follow the console convention, so all ones means idle. */
package adam_ctrl_pkg;

        // ======================================================================
        // Widths with a meaning
        // ======================================================================

        // Keypad order, index 0 is digit 0, set bit means pressed
        typedef logic [19:0] keypad_vec_t;

        // Raw joystick word from the host, bit 0 is right
        typedef logic [19:0] joy_word_t;

        // Code returned on p1..p4 under keypad select, bit 3 goes to p1
        typedef logic [3:0] key_code_t;

        typedef logic [8:0] scan_code_t;

        localparam int NUM_PORTS = 2;

        // ======================================================================
        // Bundles
        // ======================================================================

        // Keyboard event, a new one is flagged by flipping toggle
        typedef struct packed {
                logic       toggle;
                logic       pressed;
                scan_code_t code;
        } ps2_event_t;

        // Strobes from the console, both active low
        typedef struct packed {
                logic keypad_sel_n;
                logic joystick_sel_n;
        } port_select_t;

        // Answer of one port, all lines active low
        typedef struct packed {
                logic p1_n;
                logic p2_n;
                logic p3_n;
                logic p4_n;
                logic fire_n;
        } port_lines_t;

        // Positions in keypad_vec_t above the digits
        localparam int KP_STAR   = 10;
        localparam int KP_NUMBER = 11;
        localparam int KP_PURPLE = 12;
        localparam int KP_BLUE   = 13;
        localparam int KP_UP     = 14;
        localparam int KP_DOWN   = 15;
        localparam int KP_LEFT   = 16;
        localparam int KP_RIGHT  = 17;
        localparam int KP_FIRE1  = 18;
        localparam int KP_FIRE2  = 19;

        // Console key codes
        localparam key_code_t KEY_CODE_0      = 4'b0011;
        localparam key_code_t KEY_CODE_1      = 4'b1110;
        localparam key_code_t KEY_CODE_2      = 4'b1101;
        localparam key_code_t KEY_CODE_3      = 4'b0110;
        localparam key_code_t KEY_CODE_4      = 4'b0001;
        localparam key_code_t KEY_CODE_5      = 4'b1001;
        localparam key_code_t KEY_CODE_6      = 4'b0111;
        localparam key_code_t KEY_CODE_7      = 4'b1100;
        localparam key_code_t KEY_CODE_8      = 4'b1000;
        localparam key_code_t KEY_CODE_9      = 4'b1011;
        localparam key_code_t KEY_CODE_STAR   = 4'b1010;
        localparam key_code_t KEY_CODE_NUMBER = 4'b0101;
        localparam key_code_t KEY_CODE_PURPLE = 4'b0100;
        localparam key_code_t KEY_CODE_BLUE   = 4'b0010;
        localparam key_code_t KEY_CODE_NONE   = 4'b1111;

endpackage

// File: logic/ps2_keypad_decoder.sv
/* Only the low 8 bits of the scan code are matched, extended codes alias plain ones.
   The source must not flip the toggle twice between two clock edges. */
`timescale 1ns/1ps

module ps2_keypad_decoder (
        input  logic                     clk_sys,
        input  logic                     reset_i,
        input  adam_ctrl_pkg::ps2_event_t ps2_event_i,
        output adam_ctrl_pkg::keypad_vec_t kbd_keypad_o
);

        // Main row digits
        localparam logic [7:0] SC_ROW_1 = 8'h16;
        localparam logic [7:0] SC_ROW_2 = 8'h1E;
        localparam logic [7:0] SC_ROW_3 = 8'h26;
        localparam logic [7:0] SC_ROW_4 = 8'h25;
        localparam logic [7:0] SC_ROW_5 = 8'h2E;
        localparam logic [7:0] SC_ROW_6 = 8'h36;
        localparam logic [7:0] SC_ROW_7 = 8'h3D;
        localparam logic [7:0] SC_ROW_8 = 8'h3E;
        localparam logic [7:0] SC_ROW_9 = 8'h46;
        localparam logic [7:0] SC_ROW_0 = 8'h45;
        // Numeric pad digits
        localparam logic [7:0] SC_PAD_1 = 8'h69;
        localparam logic [7:0] SC_PAD_2 = 8'h72;
        localparam logic [7:0] SC_PAD_3 = 8'h7A;
        localparam logic [7:0] SC_PAD_4 = 8'h6B;
        localparam logic [7:0] SC_PAD_5 = 8'h73;
        localparam logic [7:0] SC_PAD_6 = 8'h74;
        localparam logic [7:0] SC_PAD_7 = 8'h6C;
        localparam logic [7:0] SC_PAD_8 = 8'h75;
        localparam logic [7:0] SC_PAD_9 = 8'h7D;
        localparam logic [7:0] SC_PAD_0 = 8'h70;
        localparam logic [7:0] SC_STAR   = 8'h7C;
        localparam logic [7:0] SC_LSHIFT = 8'h12;
        localparam logic [7:0] SC_RSHIFT = 8'h59;
        localparam logic [7:0] SC_MINUS  = 8'h7B;

        logic       toggle_prev;
        logic       event_new;
        logic [9:0] digit_q;
        logic       star_q;
        logic       shift_q;
        logic       minus_q;

        assign event_new = ps2_event_i.toggle != toggle_prev;

        // Tracks the input through reset so no event fires on release
        always_ff @(posedge clk_sys) begin
                toggle_prev <= ps2_event_i.toggle;
        end

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        digit_q <= '0;
                        star_q  <= 1'b0;
                        shift_q <= 1'b0;
                        minus_q <= 1'b0;
                end else if (event_new) begin
                        case (ps2_event_i.code[7:0])
                                SC_ROW_0, SC_PAD_0: digit_q[0] <= ps2_event_i.pressed;
                                SC_ROW_1, SC_PAD_1: digit_q[1] <= ps2_event_i.pressed;
                                SC_ROW_2, SC_PAD_2: digit_q[2] <= ps2_event_i.pressed;
                                SC_ROW_3, SC_PAD_3: digit_q[3] <= ps2_event_i.pressed;
                                SC_ROW_4, SC_PAD_4: digit_q[4] <= ps2_event_i.pressed;
                                SC_ROW_5, SC_PAD_5: digit_q[5] <= ps2_event_i.pressed;
                                SC_ROW_6, SC_PAD_6: digit_q[6] <= ps2_event_i.pressed;
                                SC_ROW_7, SC_PAD_7: digit_q[7] <= ps2_event_i.pressed;
                                SC_ROW_8, SC_PAD_8: digit_q[8] <= ps2_event_i.pressed;
                                SC_ROW_9, SC_PAD_9: digit_q[9] <= ps2_event_i.pressed;
                                SC_STAR:             star_q     <= ps2_event_i.pressed;
                                SC_LSHIFT, SC_RSHIFT: shift_q   <= ps2_event_i.pressed;
                                SC_MINUS:            minus_q    <= ps2_event_i.pressed;
                                default: ;
                        endcase
                end
        end

        // ======================================================================
        // Keypad view, shift+8 doubles as star and shift+3 as number sign
        // ======================================================================
        always_comb begin
                kbd_keypad_o = '0;
                kbd_keypad_o[9:0] = digit_q;
                kbd_keypad_o[adam_ctrl_pkg::KP_STAR] = star_q | (shift_q & digit_q[8]);
                kbd_keypad_o[adam_ctrl_pkg::KP_NUMBER] = minus_q | (shift_q & digit_q[3]);
        end

        // Held keys come out of reset released
        a_clear_after_reset: assert property (
                @(posedge clk_sys) $past(reset_i) |-> !(|{digit_q, star_q, shift_q, minus_q})
        ) else $error("held key set after reset");

endmodule

// File: logic/pad_mapper.sv
/* Two-player only: swap_i exchanges the joysticks before reordering.
   Keyboard keys are seen on both ports at once. */
`timescale 1ns/1ps

module pad_mapper (
        input  logic                       swap_i,
        input  adam_ctrl_pkg::joy_word_t   joy0_i,
        input  adam_ctrl_pkg::joy_word_t   joy1_i,
        input  adam_ctrl_pkg::keypad_vec_t kbd_keypad_i,
        output adam_ctrl_pkg::keypad_vec_t pad_o [adam_ctrl_pkg::NUM_PORTS]
);

        // Bit positions in the host joystick word
        localparam int JOY_RIGHT  = 0;
        localparam int JOY_LEFT   = 1;
        localparam int JOY_DOWN   = 2;
        localparam int JOY_UP     = 3;
        localparam int JOY_FIRE1  = 4;
        localparam int JOY_FIRE2  = 5;
        localparam int JOY_STAR   = 6;
        localparam int JOY_NUMBER = 7;
        localparam int JOY_DIGIT0 = 8;
        localparam int JOY_PURPLE = 18;
        localparam int JOY_BLUE   = 19;

        adam_ctrl_pkg::joy_word_t joy_sel [adam_ctrl_pkg::NUM_PORTS];

        function automatic adam_ctrl_pkg::keypad_vec_t reorder(
                input adam_ctrl_pkg::joy_word_t joy
        );
                adam_ctrl_pkg::keypad_vec_t kp;

                kp[9:0] = joy[JOY_DIGIT0 +: 10];
                kp[adam_ctrl_pkg::KP_STAR]   = joy[JOY_STAR];
                kp[adam_ctrl_pkg::KP_NUMBER] = joy[JOY_NUMBER];
                kp[adam_ctrl_pkg::KP_PURPLE] = joy[JOY_PURPLE];
                kp[adam_ctrl_pkg::KP_BLUE]   = joy[JOY_BLUE];
                kp[adam_ctrl_pkg::KP_UP]     = joy[JOY_UP];
                kp[adam_ctrl_pkg::KP_DOWN]   = joy[JOY_DOWN];
                kp[adam_ctrl_pkg::KP_LEFT]   = joy[JOY_LEFT];
                kp[adam_ctrl_pkg::KP_RIGHT]  = joy[JOY_RIGHT];
                kp[adam_ctrl_pkg::KP_FIRE1]  = joy[JOY_FIRE1];
                kp[adam_ctrl_pkg::KP_FIRE2]  = joy[JOY_FIRE2];
                return kp;
        endfunction

        // Player A drives port 0 unless swapped
        assign joy_sel[0] = swap_i ? joy1_i : joy0_i;
        assign joy_sel[1] = swap_i ? joy0_i : joy1_i;

        always_comb begin
                for (int p = 0; p < adam_ctrl_pkg::NUM_PORTS; p++) begin
                        pad_o[p] = reorder(joy_sel[p]) | kbd_keypad_i;
                end
        end

endmodule

// File: logic/port_encoder.sv
/* Purely combinational, the console samples the lines while it holds a strobe low.
   With both strobes low the keypad and joystick answers are ANDed together. */
`timescale 1ns/1ps

module port_encoder (
        input  adam_ctrl_pkg::port_select_t select_i,
        input  adam_ctrl_pkg::keypad_vec_t  pad_i,
        output adam_ctrl_pkg::port_lines_t  lines_o
);

        adam_ctrl_pkg::key_code_t key_code;
        adam_ctrl_pkg::key_code_t kp_lines;
        adam_ctrl_pkg::key_code_t js_lines;
        adam_ctrl_pkg::key_code_t all_lines;
        logic                     kp_fire_n;
        logic                     js_fire_n;

        function automatic adam_ctrl_pkg::key_code_t index_code(input int idx);
                adam_ctrl_pkg::key_code_t code;

                case (idx)
                        0:  code = adam_ctrl_pkg::KEY_CODE_0;
                        1:  code = adam_ctrl_pkg::KEY_CODE_1;
                        2:  code = adam_ctrl_pkg::KEY_CODE_2;
                        3:  code = adam_ctrl_pkg::KEY_CODE_3;
                        4:  code = adam_ctrl_pkg::KEY_CODE_4;
                        5:  code = adam_ctrl_pkg::KEY_CODE_5;
                        6:  code = adam_ctrl_pkg::KEY_CODE_6;
                        7:  code = adam_ctrl_pkg::KEY_CODE_7;
                        8:  code = adam_ctrl_pkg::KEY_CODE_8;
                        9:  code = adam_ctrl_pkg::KEY_CODE_9;
                        adam_ctrl_pkg::KP_STAR:   code = adam_ctrl_pkg::KEY_CODE_STAR;
                        adam_ctrl_pkg::KP_NUMBER: code = adam_ctrl_pkg::KEY_CODE_NUMBER;
                        adam_ctrl_pkg::KP_PURPLE: code = adam_ctrl_pkg::KEY_CODE_PURPLE;
                        adam_ctrl_pkg::KP_BLUE:   code = adam_ctrl_pkg::KEY_CODE_BLUE;
                        default: code = adam_ctrl_pkg::KEY_CODE_NONE;
                endcase
                return code;
        endfunction

        // ======================================================================
        // Keypad side, lowest pressed index wins
        // ======================================================================
        always_comb begin
                key_code = adam_ctrl_pkg::KEY_CODE_NONE;
                // Scan downwards so the lowest set index is written last
                for (int i = adam_ctrl_pkg::KP_BLUE; i >= 0; i--) begin
                        if (pad_i[i]) begin
                                key_code = index_code(i);
                        end
                end
        end

        assign kp_lines  = select_i.keypad_sel_n ? 4'b1111 : key_code;
        assign kp_fire_n = select_i.keypad_sel_n | ~pad_i[adam_ctrl_pkg::KP_FIRE2];

        // ======================================================================
        // Joystick side
        // ======================================================================
        assign js_lines = select_i.joystick_sel_n ? 4'b1111 :
                          ~{pad_i[adam_ctrl_pkg::KP_UP],   pad_i[adam_ctrl_pkg::KP_DOWN],
                            pad_i[adam_ctrl_pkg::KP_LEFT], pad_i[adam_ctrl_pkg::KP_RIGHT]};
        assign js_fire_n = select_i.joystick_sel_n | ~pad_i[adam_ctrl_pkg::KP_FIRE1];

        // Open-drain style merge of both answers
        assign all_lines = kp_lines & js_lines;

        assign lines_o.p1_n   = all_lines[3];
        assign lines_o.p2_n   = all_lines[2];
        assign lines_o.p3_n   = all_lines[1];
        assign lines_o.p4_n   = all_lines[0];
        assign lines_o.fire_n = kp_fire_n & js_fire_n;

        // Idle port must float high whatever the pad holds
        always_comb begin
                if (select_i.keypad_sel_n && select_i.joystick_sel_n) begin
                        a_idle_high: assert final (lines_o == '1)
                                else $error("port lines active with both strobes high");
                end
        end

endmodule

// File: logic/adam_controls_top.sv
/* Controller input path only, no console core attached.
   Keyboard state shows on the ports one clk_sys edge after a toggle flip. */
`timescale 1ns/1ps

module adam_controls_top (
        input  logic                        clk_sys,
        input  logic                        reset_i,
        input  adam_ctrl_pkg::ps2_event_t   ps2_event_i,
        input  logic                        swap_i,
        input  adam_ctrl_pkg::joy_word_t    joy0_i,
        input  adam_ctrl_pkg::joy_word_t    joy1_i,
        input  adam_ctrl_pkg::port_select_t select_i [adam_ctrl_pkg::NUM_PORTS],
        output adam_ctrl_pkg::port_lines_t  lines_o  [adam_ctrl_pkg::NUM_PORTS]
);

        adam_ctrl_pkg::keypad_vec_t kbd_keypad;
        adam_ctrl_pkg::keypad_vec_t pad [adam_ctrl_pkg::NUM_PORTS];

        // Keyboard emulation of the keypad
        ps2_keypad_decoder u_decoder (
                .clk_sys      (clk_sys),
                .reset_i      (reset_i),
                .ps2_event_i  (ps2_event_i),
                .kbd_keypad_o (kbd_keypad)
        );

        pad_mapper u_mapper (
                .swap_i       (swap_i),
                .joy0_i       (joy0_i),
                .joy1_i       (joy1_i),
                .kbd_keypad_i (kbd_keypad),
                .pad_o        (pad)
        );

        // ======================================================================
        // One encoder per controller port
        // ======================================================================
        for (genvar p = 0; p < adam_ctrl_pkg::NUM_PORTS; p++) begin : g_port
                port_encoder u_encoder (
                        .select_i (select_i[p]),
                        .pad_i    (pad[p]),
                        .lines_o  (lines_o[p])
                );
        end

endmodule

// File: verif/tb_adam_tasks.svh
/* Driver, check and directed test tasks, included inside the testbench module.
   Relies on the module's DUT signals and on joy_bit_of and expected_code. */
`ifndef TB_ADAM_TASKS_SVH
`define TB_ADAM_TASKS_SVH

// =====================================================================
// Checks and waits
// =====================================================================
task automatic check_equal(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
                $display("mismatch at %0t: %s is %0h, expected %0h",
                         $time, name, actual, expected);
                $display("Something failed");
                $fatal(1, "value check failed");
        end
endtask

// Polls one port on falling edges until it shows the expected lines
task automatic wait_lines(input int port, input adam_ctrl_pkg::port_lines_t expected,
                          input string what);
        bit seen;

        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
                @(negedge clk_sys);
                seen = (lines[port] == expected);
        end
        if (!seen) begin
                $display("timeout: port %0d never showed %s", port, what);
                $display("Something failed");
                $fatal(1, "wait for port lines timed out");
        end
endtask

// Mid low phase, combinational outputs are stable here
task automatic settle();
        #(HALF_PERIOD / 2);
endtask

// =====================================================================
// Drivers
// =====================================================================
task automatic apply_pads(input logic swap_v, input adam_ctrl_pkg::joy_word_t j0,
                          input adam_ctrl_pkg::joy_word_t j1);
        @(negedge clk_sys);
        swap = swap_v;
        joy0 = j0;
        joy1 = j1;
endtask

task automatic apply_select(input int port, input logic kp_n, input logic js_n);
        @(negedge clk_sys);
        select[port].keypad_sel_n   = kp_n;
        select[port].joystick_sel_n = js_n;
endtask

// One keyboard event, flagged by flipping the toggle
task automatic send_key(input logic [7:0] code, input logic pressed);
        @(negedge clk_sys);
        ps2_event.toggle  = ~ps2_event.toggle;
        ps2_event.pressed = pressed;
        ps2_event.code    = {1'b0, code};
endtask

// =====================================================================
// Directed tests
// =====================================================================
task automatic idle_after_reset();
        settle();
        check_equal("lines_o[0]", 32'(lines[0]), 32'(5'h1f));
        check_equal("lines_o[1]", 32'(lines[1]), 32'(5'h1f));
endtask

task automatic keypad_priority();
        adam_ctrl_pkg::joy_word_t joy;
        logic [13:0]              keys;
        logic                     fire2;
        adam_ctrl_pkg::key_code_t code;

        apply_select(0, 1'b0, 1'b1);
        for (int round = 0; round < 20; round++) begin
                joy  = '0;
                keys = '0;
                for (int k = 0; k < 14; k++) begin
                        keys[k] = (($urandom % 4) == 0);
                        if (keys[k]) begin
                                joy[joy_bit_of(k)] = 1'b1;
                        end
                end
                fire2  = (($urandom % 2) == 1);
                joy[5] = fire2;
                code   = expected_code(keys);
                apply_pads(1'b0, joy, '0);
                settle();
                check_equal("lines_o[0]", 32'(lines[0]), 32'({code, ~fire2}));
        end
endtask

// Joystick select alone, then both selects low
task automatic joystick_side();
        adam_ctrl_pkg::joy_word_t joy;
        logic [4:0]               dirs;
        logic [4:0]               js_exp;
        logic [4:0]               kp_exp;
        logic                     fire2;
        int                       digit;

        apply_select(0, 1'b1, 1'b0);
        for (int round = 0; round < 20; round++) begin
                if (round == 10) begin
                        apply_select(0, 1'b0, 1'b0);
                end
                dirs      = 5'($urandom);
                digit     = $urandom % 10;
                fire2     = (($urandom % 2) == 1);
                joy       = '0;
                joy[4:0]  = dirs;
                joy[5]    = fire2;
                joy[8 + digit] = 1'b1;
                js_exp    = {~dirs[3], ~dirs[2], ~dirs[1], ~dirs[0], ~dirs[4]};
                kp_exp    = (round >= 10) ? {CODE_TABLE[digit], ~fire2} : 5'h1f;
                apply_pads(1'b0, joy, '0);
                settle();
                check_equal("lines_o[0]", 32'(lines[0]), 32'(js_exp & kp_exp));
        end
endtask

task automatic player_swap();
        adam_ctrl_pkg::joy_word_t joy;

        apply_select(0, 1'b0, 1'b1);
        apply_select(1, 1'b0, 1'b1);
        joy     = '0;
        joy[15] = 1'b1;
        apply_pads(1'b1, '0, joy);
        settle();
        check_equal("lines_o[0]", 32'(lines[0]), 32'({adam_ctrl_pkg::KEY_CODE_7, 1'b1}));
        check_equal("lines_o[1]", 32'(lines[1]), 32'({adam_ctrl_pkg::KEY_CODE_NONE, 1'b1}));
        joy     = '0;
        joy[12] = 1'b1;
        apply_pads(1'b1, joy, '0);
        settle();
        check_equal("lines_o[0]", 32'(lines[0]), 32'({adam_ctrl_pkg::KEY_CODE_NONE, 1'b1}));
        check_equal("lines_o[1]", 32'(lines[1]), 32'({adam_ctrl_pkg::KEY_CODE_4, 1'b1}));
        apply_pads(1'b0, '0, '0);
endtask

task automatic keyboard_emulation();
        adam_ctrl_pkg::port_lines_t none_lines;

        none_lines = {adam_ctrl_pkg::KEY_CODE_NONE, 1'b1};
        apply_select(0, 1'b0, 1'b1);
        apply_select(1, 1'b0, 1'b1);
        // Main row 5, press then release
        send_key(8'h2E, 1'b1);
        wait_lines(0, {adam_ctrl_pkg::KEY_CODE_5, 1'b1}, "key code 5");
        wait_lines(1, {adam_ctrl_pkg::KEY_CODE_5, 1'b1}, "key code 5");
        send_key(8'h2E, 1'b0);
        wait_lines(0, none_lines, "no key");
        wait_lines(1, none_lines, "no key");
        // Shift with 8 adds star, digit 8 still has the lower index
        send_key(8'h12, 1'b1);
        send_key(8'h3E, 1'b1);
        wait_lines(0, {adam_ctrl_pkg::KEY_CODE_8, 1'b1}, "key code 8");
        check_equal("kbd_keypad", 32'(dut0.u_decoder.kbd_keypad_o), 32'(20'h00500));
        send_key(8'h3E, 1'b0);
        send_key(8'h12, 1'b0);
        wait_lines(0, none_lines, "no key");
        // Keypad minus is the number sign
        send_key(8'h7B, 1'b1);
        wait_lines(0, {adam_ctrl_pkg::KEY_CODE_NUMBER, 1'b1}, "number sign");
        wait_lines(1, {adam_ctrl_pkg::KEY_CODE_NUMBER, 1'b1}, "number sign");
        send_key(8'h7B, 1'b0);
        wait_lines(0, none_lines, "no key");
endtask

`endif

// File: verif/tb_adam_controls.sv
/* Directed tests of the controller input path, seeded random stimulus.
   Inputs change on the falling clk_sys edge, combinational results are read mid low phase. */
`timescale 1ns/1ps

module tb_adam_controls;

        localparam int HALF_PERIOD = 20;
        localparam int WAIT_LIMIT  = 8;

        // Expected console code per keypad index 0..13
        localparam adam_ctrl_pkg::key_code_t CODE_TABLE [14] = '{
                adam_ctrl_pkg::KEY_CODE_0, adam_ctrl_pkg::KEY_CODE_1,
                adam_ctrl_pkg::KEY_CODE_2, adam_ctrl_pkg::KEY_CODE_3,
                adam_ctrl_pkg::KEY_CODE_4, adam_ctrl_pkg::KEY_CODE_5,
                adam_ctrl_pkg::KEY_CODE_6, adam_ctrl_pkg::KEY_CODE_7,
                adam_ctrl_pkg::KEY_CODE_8, adam_ctrl_pkg::KEY_CODE_9,
                adam_ctrl_pkg::KEY_CODE_STAR, adam_ctrl_pkg::KEY_CODE_NUMBER,
                adam_ctrl_pkg::KEY_CODE_PURPLE, adam_ctrl_pkg::KEY_CODE_BLUE
        };

        logic                        clk_sys;
        logic                        reset_i;
        adam_ctrl_pkg::ps2_event_t   ps2_event;
        logic                        swap;
        adam_ctrl_pkg::joy_word_t    joy0;
        adam_ctrl_pkg::joy_word_t    joy1;
        adam_ctrl_pkg::port_select_t select [adam_ctrl_pkg::NUM_PORTS];
        adam_ctrl_pkg::port_lines_t  lines  [adam_ctrl_pkg::NUM_PORTS];

        always #(HALF_PERIOD) clk_sys = ~clk_sys;

        adam_controls_top dut0 (
                .clk_sys     (clk_sys),
                .reset_i     (reset_i),
                .ps2_event_i (ps2_event),
                .swap_i      (swap),
                .joy0_i      (joy0),
                .joy1_i      (joy1),
                .select_i    (select),
                .lines_o     (lines)
        );

        `include "tb_adam_tasks.svh"

        // =====================================================================
        // Host joystick bit of a keypad index
        // =====================================================================
        function automatic int joy_bit_of(input int idx);
                int pos;

                case (idx)
                        10: pos = 6;
                        11: pos = 7;
                        12: pos = 18;
                        13: pos = 19;
                        default: pos = 8 + idx;
                endcase
                return pos;
        endfunction

        // Lowest pressed keypad index gives the code
        function automatic adam_ctrl_pkg::key_code_t expected_code(input logic [13:0] keys);
                adam_ctrl_pkg::key_code_t code;
                bit                       found;

                code  = adam_ctrl_pkg::KEY_CODE_NONE;
                found = 1'b0;
                for (int k = 0; k < 14; k++) begin
                        if (keys[k] && !found) begin
                                code  = CODE_TABLE[k];
                                found = 1'b1;
                        end
                end
                return code;
        endfunction

        initial begin
                void'($urandom(72));
                clk_sys     = 1'b0;
                reset_i     = 1'b1;
                ps2_event   = '0;
                swap        = 1'b0;
                joy0        = '0;
                joy1        = '0;
                for (int p = 0; p < adam_ctrl_pkg::NUM_PORTS; p++) begin
                        select[p] = '1;
                end

                repeat (4) @(posedge clk_sys);
                @(negedge clk_sys);
                reset_i = 1'b0;

                idle_after_reset();
                keypad_priority();
                joystick_side();
                player_swap();
                keyboard_emulation();

                $display("Everything OK");
                $finish;
        end

endmodule

// File: adam_controls.f
+incdir+verif
logic/adam_ctrl_pkg.sv
logic/ps2_keypad_decoder.sv
logic/pad_mapper.sv
logic/port_encoder.sv
logic/adam_controls_top.sv
verif/tb_adam_controls.sv

// File: Makefile
# Verilator simulation of the controller input path
# The simulator exit status carries pass or fail

TOP := tb_adam_controls

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert \
		--top-module $(TOP) \
		-f adam_controls.f \
		-Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
